/* design/stream_pkg.sv */
// beat stream shared types
package stream_pkg;

    // bytes per 64-bit beat
    localparam int BEAT_BYTES = 8;

    typedef logic [7:0]              byte_t;  // one stream byte
    typedef logic [BEAT_BYTES*8-1:0] data_t;  // beat data, lane 0 in the low byte
    typedef logic [BEAT_BYTES-1:0]   keep_t;  // bit i set when lane i holds a byte

    // one FIFO entry, 74 bits in all
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;  // final beat of a frame
        logic  user;  // error seen on some byte of this beat
    } beat_t;

    // byte count of a frame
    typedef logic [15:0] count_t;

    // byte sum of a frame, wraps modulo 65536
    typedef logic [15:0] sum_t;

endpackage

/* design/beat_stream_if.sv */
// beat stream interface
`timescale 1ns/10ps

interface beat_stream_if;

    // a transfer happens on an edge where valid and ready are both high
    stream_pkg::data_t data;
    stream_pkg::keep_t keep;
    logic              last;  // marks the final beat of a frame
    logic              user;  // error flag carried with the beat
    logic              valid;
    logic              ready;

    // the source holds valid and payload steady until ready
    modport src (
        output data,
        output keep,
        output last,
        output user,
        output valid,
        input  ready
    );

    // ready may look at valid
    modport snk (
        input  data,
        input  keep,
        input  last,
        input  user,
        input  valid,
        output ready
    );

endinterface

/* design/byte_packer.sv */
// byte to beat packer
`timescale 1ns/10ps

module byte_packer (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::byte_t in_data,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              in_last,
    input  logic              in_user,
    beat_stream_if.src        out
);

    localparam int LANE_W = $clog2(stream_pkg::BEAT_BYTES);

    logic [LANE_W-1:0] lane_q;      // lane the next byte lands in
    stream_pkg::data_t data_q;      // beat under construction or waiting
    stream_pkg::keep_t keep_q;
    logic              last_q;
    logic              user_q;
    logic              valid_q;     // beat is complete and offered downstream

    logic              byte_acc;
    logic              beat_acc;
    logic              beat_done;
    stream_pkg::keep_t keep_base;
    logic              user_base;

    // a waiting beat blocks input unless it leaves on this very edge
    assign in_ready = !valid_q || out.ready;

    assign byte_acc  = in_valid && in_ready;
    assign beat_acc  = valid_q && out.ready;
    assign beat_done = (lane_q == LANE_W'(stream_pkg::BEAT_BYTES - 1)) || in_last;

    // a byte taken while a beat is leaving starts a fresh beat
    assign keep_base = valid_q ? '0 : keep_q;
    assign user_base = valid_q ? 1'b0 : user_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_q  <= '0;
            keep_q  <= '0;
            user_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (beat_acc) begin
                valid_q <= 1'b0;
                keep_q  <= '0;
                user_q  <= 1'b0;
            end
            if (byte_acc) begin
                keep_q <= keep_base | (stream_pkg::keep_t'(1) << lane_q);
                user_q <= user_base | in_user;  // any bad byte taints the beat
                if (beat_done) begin
                    valid_q <= 1'b1;  // offered on the next cycle
                    lane_q  <= '0;
                end else begin
                    lane_q <= lane_q + 1'b1;
                end
            end
        end
    end

    // payload lanes, stale bytes above the keep mask are ignored downstream
    always_ff @(posedge clk) begin
        if (byte_acc) begin
            data_q[lane_q*8 +: 8] <= in_data;
            last_q                <= in_last;
        end
    end

    assign out.data  = data_q;
    assign out.keep  = keep_q;
    assign out.last  = last_q;
    assign out.user  = user_q;
    assign out.valid = valid_q;

    // an offered beat stays put until the FIFO takes it
    a_hold_beat: assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable({out.data, out.keep, out.last, out.user}))
        else $error("packer dropped or changed a beat before ready");

endmodule

/* design/srl_fifo.sv */
// shift register beat FIFO
`timescale 1ns/10ps

module srl_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    beat_stream_if.snk                 in,
    beat_stream_if.src                 out,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    stream_pkg::beat_t mem [DEPTH];  // entry 0 is always the newest

    logic [CNT_W-1:0]  ptr_q;        // number of beats held
    logic              full_q;
    logic              empty_q;
    logic              full_next;
    logic              empty_next;
    logic              shift;
    logic              inc;
    logic              dec;
    logic [IDX_W-1:0]  rd_idx;
    stream_pkg::beat_t wr_beat;
    stream_pkg::beat_t rd_beat;

    // oldest entry sits one below the pointer
    assign rd_idx  = IDX_W'(ptr_q - 1'b1);
    assign rd_beat = mem[rd_idx];
    assign wr_beat = '{data: in.data, keep: in.keep, last: in.last, user: in.user};

    assign in.ready  = !full_q;
    assign out.valid = !empty_q;
    assign out.data  = rd_beat.data;
    assign out.keep  = rd_beat.keep;
    assign out.last  = rd_beat.last;
    assign out.user  = rd_beat.user;
    assign count     = ptr_q;

    always_comb begin
        shift      = 1'b0;
        inc        = 1'b0;
        dec        = 1'b0;
        full_next  = full_q;
        empty_next = empty_q;
        if (out.ready && in.valid && !full_q) begin
            // write alongside a read keeps the count, into empty it only grows
            shift      = 1'b1;
            inc        = (ptr_q == '0);
            empty_next = 1'b0;
        end else if (out.ready && out.valid) begin
            dec        = 1'b1;
            full_next  = 1'b0;
            empty_next = (ptr_q == CNT_W'(1));
        end else if (in.valid && in.ready) begin
            shift      = 1'b1;
            inc        = 1'b1;
            full_next  = (ptr_q == CNT_W'(DEPTH - 1));
            empty_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q   <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            if (inc) begin
                ptr_q <= ptr_q + 1'b1;
            end else if (dec) begin
                ptr_q <= ptr_q - 1'b1;
            end
            full_q  <= full_next;
            empty_q <= empty_next;
        end
    end

    // every write pushes the whole chain one step deeper
    always_ff @(posedge clk) begin
        if (shift) begin
            mem[0] <= wr_beat;
            for (int i = 1; i < DEPTH; i++) begin
                mem[i] <= mem[i-1];
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH))
        else $error("FIFO count above depth");

    // full flag and pointer must agree so a full FIFO never takes a write
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        ptr_q == CNT_W'(DEPTH) |-> !(in.valid && in.ready))
        else $error("FIFO accepted a write while full");

endmodule

/* design/frame_summer.sv */
// per frame byte summer
`timescale 1ns/10ps

module frame_summer (
    input  logic               clk,
    input  logic               rst,
    beat_stream_if.snk         in,
    output stream_pkg::count_t res_count,
    output stream_pkg::sum_t   res_sum,
    output logic               res_error,
    output logic               res_valid,
    input  logic               res_ready
);

    stream_pkg::count_t cnt_q;    // bytes so far, the result once valid is up
    stream_pkg::sum_t   sum_q;
    logic               err_q;
    logic               valid_q;

    stream_pkg::count_t beat_bytes;
    stream_pkg::sum_t   beat_sum;
    logic               beat_acc;

    // a held result stalls the beat stream
    assign in.ready = !valid_q;
    assign beat_acc = in.valid && in.ready;

    // count and add only the lanes marked in keep
    always_comb begin
        beat_bytes = '0;
        beat_sum   = '0;
        for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
            if (in.keep[i]) begin
                beat_bytes = beat_bytes + 1'b1;
                beat_sum   = beat_sum + stream_pkg::sum_t'(in.data[i*8 +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q   <= '0;
            sum_q   <= '0;
            err_q   <= 1'b0;
            valid_q <= 1'b0;
        end else if (valid_q) begin
            if (res_ready) begin
                cnt_q   <= '0;  // start the next frame from zero
                sum_q   <= '0;
                err_q   <= 1'b0;
                valid_q <= 1'b0;
            end
        end else if (beat_acc) begin
            cnt_q   <= cnt_q + beat_bytes;
            sum_q   <= sum_q + beat_sum;  // wraps on overflow
            err_q   <= err_q | in.user;
            valid_q <= in.last;           // totals freeze as the result
        end
    end

    assign res_count = cnt_q;
    assign res_sum   = sum_q;
    assign res_error = err_q;
    assign res_valid = valid_q;

    // the packer fills lanes from zero up so no beat may skip lane 0
    a_keep_lane0: assert property (@(posedge clk) disable iff (rst)
        in.valid && in.ready |-> in.keep[0])
        else $error("beat accepted without lane 0");

endmodule

/* design/frame_sum_top.sv */
// frame sum top level
`timescale 1ns/10ps

module frame_sum_top #(
    parameter int DEPTH = 16  // beats held between packer and summer
) (
    input  logic                       clk,
    input  logic                       rst,

    // byte stream in
    input  stream_pkg::byte_t          in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic                       in_last,
    input  logic                       in_user,

    // one result per frame
    output stream_pkg::count_t         res_count,
    output stream_pkg::sum_t           res_sum,
    output logic                       res_error,
    output logic                       res_valid,
    input  logic                       res_ready,

    output logic [$clog2(DEPTH+1)-1:0] fifo_count  // beats in the FIFO
);

    beat_stream_if pk2ff ();  // packer to FIFO
    beat_stream_if ff2fs ();  // FIFO to summer

    byte_packer u_packer (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_last  (in_last),
        .in_user  (in_user),
        .out      (pk2ff.src)
    );

    srl_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .in    (pk2ff.snk),
        .out   (ff2fs.src),
        .count (fifo_count)
    );

    frame_summer u_summer (
        .clk       (clk),
        .rst       (rst),
        .in        (ff2fs.snk),
        .res_count (res_count),
        .res_sum   (res_sum),
        .res_error (res_error),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

/* tests/frame_sum_tb.sv */
// frame sum testbench
`timescale 1ns/10ps

module frame_sum_tb;

    localparam int DEPTH      = 4;  // small so held results reach the input
    localparam int NUM_FIXED  = 14;
    localparam int NUM_FRAMES = NUM_FIXED + 24;
    localparam int LVL_W      = $clog2(DEPTH + 1);

    // one table row, stimulus first and then the expected result
    typedef struct packed {
        int                 len;
        stream_pkg::byte_t  first;     // bytes count up from here and wrap
        int                 user_idx;  // byte carrying user, -1 for none
        int                 stall;     // percent of cycles with res_ready low
        stream_pkg::count_t exp_count;
        stream_pkg::sum_t   exp_sum;
        logic               exp_err;
    } frame_t;

    logic clk, rst, in_valid, in_ready, in_last, in_user;
    logic res_error, res_valid, res_ready;
    stream_pkg::byte_t  in_data;
    stream_pkg::count_t res_count;
    stream_pkg::sum_t   res_sum;
    logic [LVL_W-1:0]   fifo_count;

    frame_t frames [NUM_FRAMES];
    int     n_frames     = 0;
    int     total_bytes  = 0;
    int     limit_cycles = 0;  // watchdog stays idle until the table exists

    frame_sum_top #(.DEPTH(DEPTH)) uut (
        .clk(clk), .rst(rst), .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .in_last(in_last), .in_user(in_user), .res_count(res_count), .res_sum(res_sum),
        .res_error(res_error), .res_valid(res_valid), .res_ready(res_ready),
        .fifo_count(fifo_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_count(input string name, input stream_pkg::count_t exp,
                               input stream_pkg::count_t got);
        if (got !== exp) fail_run($sformatf("error %s expected %h got %h", name, exp, got));
    endtask

    task automatic check_sum(input string name, input stream_pkg::sum_t exp,
                             input stream_pkg::sum_t got);
        if (got !== exp) fail_run($sformatf("error %s expected %h got %h", name, exp, got));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) fail_run($sformatf("error %s expected %h got %h", name, exp, got));
    endtask

    task automatic check_level(input string name, input logic [LVL_W-1:0] exp,
                               input logic [LVL_W-1:0] got);
        if (got !== exp) fail_run($sformatf("error %s expected %h got %h", name, exp, got));
    endtask

    // sum of the frame bytes modulo 65536, each byte wrapping at 8 bits
    function automatic stream_pkg::sum_t byte_total(input stream_pkg::byte_t first,
                                                    input int len);
        stream_pkg::sum_t acc;
        acc = '0;
        for (int k = 0; k < len; k++) acc = acc + stream_pkg::sum_t'(stream_pkg::byte_t'(first + k));
        return acc;
    endfunction

    function automatic void add_frame(input int len, input stream_pkg::byte_t first,
                                      input int user_idx, input int stall);
        frame_t f;
        f.len       = len;
        f.first     = first;
        f.user_idx  = user_idx;
        f.stall     = stall;
        f.exp_count = stream_pkg::count_t'(len);
        f.exp_sum   = byte_total(first, len);
        f.exp_err   = (user_idx >= 0) && (user_idx < len);  // error only if the byte exists
        frames[n_frames] = f;
        n_frames    = n_frames + 1;
        total_bytes = total_bytes + len;
    endfunction

    // offer one byte from posedge plus 2 ns and return just after its transfer
    task automatic send_byte(input stream_pkg::byte_t d, input logic l, input logic u);
        in_data  = d;
        in_valid = 1'b1;
        in_last  = l;
        in_user  = u;
        @(negedge clk);
        while (!in_ready) @(negedge clk);  // in_ready is settled mid cycle
        @(posedge clk);
        #2;
    endtask

    // keep res_ready low until the FIFO is full and the packer has stopped the input
    task automatic hold_results();
        int waited;
        waited = 0;
        res_ready = 1'b0;
        @(negedge clk);
        while (in_ready) begin
            waited++;
            if (waited > 400) fail_run("in_ready never dropped while res_ready was held low");
            @(negedge clk);
        end
        check_level("fifo_count", LVL_W'(DEPTH), fifo_count);
        repeat (8) @(negedge clk);  // stay stalled a while longer
    endtask

    task automatic collect_result(input int i);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            #2;
            res_ready = ($urandom_range(99) >= frames[i].stall);
            @(negedge clk);
            if (res_valid && res_ready) begin  // this cycle's edge takes the result
                check_count("res_count", frames[i].exp_count, res_count);
                check_sum("res_sum", frames[i].exp_sum, res_sum);
                check_flag("res_error", frames[i].exp_err, res_error);
                got = 1'b1;
            end
        end
    endtask

    // the packer may hold one beat beyond the FIFO, never the FIFO more than DEPTH
    always @(negedge clk) begin
        if (!rst && fifo_count > LVL_W'(DEPTH))
            fail_run($sformatf("error fifo_count above %h got %h", DEPTH, fifo_count));
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        fail_run($sformatf("timeout, the frames did not finish in %0d cycles", limit_cycles));
    end

    initial begin
        int len;
        void'($urandom(27));
        rst = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        res_ready = 1'b0;
        for (int n = 1; n <= 8; n++) add_frame(n, stream_pkg::byte_t'(n * 37 + 200), -1, 0);
        add_frame(9, 8'h20, -1, 20);  // one full beat and one partial
        add_frame(16, 8'h80, -1, 20);
        add_frame(17, 8'hf8, -1, 30);
        add_frame(12, 8'h05, 5, 10);  // error frame, the next one must be clean
        add_frame(12, 8'h05, -1, 10);
        add_frame(520, 8'hff, -1, 50);  // sum passes 65535
        for (int k = NUM_FIXED; k < NUM_FRAMES; k++) begin
            len = 1 + $urandom_range(39);
            add_frame(len, stream_pkg::byte_t'($urandom_range(255)),
                      ($urandom_range(3) == 0) ? int'($urandom_range(len - 1)) : -1,
                      $urandom_range(70));
        end
        limit_cycles = 40 * total_bytes + 200;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("res_valid", 1'b0, res_valid);
        check_level("fifo_count", '0, fifo_count);
        @(posedge clk);
        #2;
        fork
            begin
                for (int i = 0; i < NUM_FRAMES; i++) begin
                    for (int b = 0; b < frames[i].len; b++)
                        send_byte(stream_pkg::byte_t'(frames[i].first + b),
                                  b == frames[i].len - 1, b == frames[i].user_idx);
                    in_valid = 1'b0;  // occasional idle cycle between frames
                    if ($urandom_range(3) == 0) begin
                        @(posedge clk);
                        #2;
                    end
                end
            end
            begin
                hold_results();
                for (int i = 0; i < NUM_FRAMES; i++) collect_result(i);
            end
        join
        @(posedge clk);
        #2;
        res_ready = 1'b1;
        repeat (20) begin  // a lost or duplicated result would show up here
            @(negedge clk);
            check_flag("res_valid", 1'b0, res_valid);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* frame_sum.f */
design/stream_pkg.sv
design/beat_stream_if.sv
design/byte_packer.sv
design/srl_fifo.sv
design/frame_summer.sv
design/frame_sum_top.sv
tests/frame_sum_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the frame sum testbench, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f frame_sum.f \
    --top-module frame_sum_tb -o frame_sum_sim || exit 1
./obj_dir/frame_sum_sim | tee /dev/stderr | grep -q "TEST PASS" && exit 0 || exit 1
